// ==== Makefile ====
# Verilator flow for the systolic array testbench

VERILATOR ?= verilator
TOP       ?= systolicTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/systolicTb.sv ====
// Directed testbench: clock, reset, stream drivers, reference model, output monitor, timeout
`timescale 1ns/1ps

module systolicTb;
    import systolicPkg::*;

    localparam int SEED           = 21;
    localparam int MAX_VEC        = 4;
    localparam int MAX_K          = 4;
    // About 200 driven beats at ten cycles each, with margin for the stall test
    localparam int TIMEOUT_CYCLES = 4000;
    // Cycles allowed for the last sums once all inputs are taken
    localparam int DRAIN_CYCLES   = 200;

    localparam int KIND_RANDOM  = 0;
    localparam int KIND_EXTREME = 1;
    localparam int KIND_MIN     = 2;
    localparam int READY_ON     = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_OFF    = 2;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [NUM_ROWS-1:0] actValid;
    actBeat_t            actIn [NUM_ROWS];
    logic [NUM_ROWS-1:0] actReady;
    logic [NUM_COLS-1:0] wgtValid;
    wgtBeat_t            wgtIn [NUM_COLS];
    logic [NUM_COLS-1:0] wgtReady;
    logic                psumValid;
    psumBeat_t           psumOut;
    logic                psumReady;

    // Operands of the current test, one row/column vector set per index v
    logic signed [ACT_WIDTH-1:0] aMat [MAX_VEC][NUM_ROWS][MAX_K];
    logic signed [WGT_WIDTH-1:0] wMat [MAX_VEC][MAX_K][NUM_COLS];
    int vecLen [MAX_VEC];
    int numVec    = 0;
    int gapPct    = 0;
    int readyMode = READY_ON;
    int cycles    = 0;
    // Expected sums per element in arrival order
    int expQ [NUM_PE][$];

    systolicTop dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .actValid  (actValid),
        .actIn     (actIn),
        .actReady  (actReady),
        .wgtValid  (wgtValid),
        .wgtIn     (wgtIn),
        .wgtReady  (wgtReady),
        .psumValid (psumValid),
        .psumOut   (psumOut),
        .psumReady (psumReady)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // ==================================================
    // Checking
    // ==================================================
    task automatic checkValue(input string name, input logic [PSUM_WIDTH-1:0] actual,
                              input logic [PSUM_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic takeResult(input psumBeat_t beat);
        int idx;
        int expected;
        idx = int'(beat.row) * NUM_COLS + int'(beat.col);
        if (expQ[idx].size() == 0) begin
            $display("Sum arrived for row %0d column %0d with no result pending",
                     beat.row, beat.col);
            $display("STATUS: FAIL");
            $fatal(1, "Unexpected output beat");
        end else begin
            expected = expQ[idx].pop_front();
            checkValue($sformatf("psumOut.value[%0d][%0d]", beat.row, beat.col),
                       beat.value, expected);
        end
    endtask

    // Handshake is stable by the falling edge, transfer happens on the next rise
    always @(negedge clk) begin
        if (rst_n && psumValid && psumReady) begin
            takeResult(psumOut);
        end
    end

    initial begin
        psumReady = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            case (readyMode)
                READY_RANDOM: psumReady = ($urandom_range(1) == 1);
                READY_OFF:    psumReady = 1'b0;
                default:      psumReady = 1'b1;
            endcase
        end
    end

    // ==================================================
    // Stimulus and reference model
    // ==================================================
    function automatic logic signed [ACT_WIDTH-1:0] pickOperand(input int kind);
        case (kind)
            KIND_MIN: return 8'sh80;
            KIND_EXTREME: begin
                case ($urandom_range(2))
                    0:       return 8'sh80;
                    1:       return 8'sh7f;
                    default: return 8'sh00;
                endcase
            end
            default: return ACT_WIDTH'($urandom);
        endcase
    endfunction

    function automatic void fillVector(input int v, input int len, input int kind);
        vecLen[v] = len;
        for (int k = 0; k < len; k++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                aMat[v][r][k] = pickOperand(kind);
            end
            for (int c = 0; c < NUM_COLS; c++) begin
                wMat[v][k][c] = pickOperand(kind);
            end
        end
    endfunction

    // Wrapped 32-bit signed dot product per element
    function automatic void pushExpected();
        int sum;
        for (int v = 0; v < numVec; v++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    sum = 0;
                    for (int k = 0; k < vecLen[v]; k++) begin
                        sum += int'(aMat[v][r][k]) * int'(wMat[v][k][c]);
                    end
                    expQ[r * NUM_COLS + c].push_back(sum);
                end
            end
        end
    endfunction

    function automatic int pendingCount();
        int total;
        total = 0;
        for (int i = 0; i < NUM_PE; i++) begin
            total += expQ[i].size();
        end
        return total;
    endfunction

    task automatic driveAct(input int row);
        actBeat_t beat;
        logic     taken;
        for (int v = 0; v < numVec; v++) begin
            for (int k = 0; k < vecLen[v]; k++) begin
                while ($urandom_range(99) < gapPct) begin
                    actValid[row] = 1'b0;
                    @(posedge clk);
                    #1;
                end
                beat.chnLast  = (k == vecLen[v] - 1);
                beat.data     = aMat[v][row][k];
                actIn[row]    = beat;
                actValid[row] = 1'b1;
                taken = 1'b0;
                while (!taken) begin
                    @(negedge clk);
                    taken = actReady[row];
                    @(posedge clk);
                    #1;
                end
            end
        end
        actValid[row] = 1'b0;
    endtask

    task automatic driveWgt(input int col);
        wgtBeat_t beat;
        logic     taken;
        for (int v = 0; v < numVec; v++) begin
            for (int k = 0; k < vecLen[v]; k++) begin
                while ($urandom_range(99) < gapPct) begin
                    wgtValid[col] = 1'b0;
                    @(posedge clk);
                    #1;
                end
                beat.chnLast  = (k == vecLen[v] - 1);
                beat.data     = wMat[v][k][col];
                wgtIn[col]    = beat;
                wgtValid[col] = 1'b1;
                taken = 1'b0;
                while (!taken) begin
                    @(negedge clk);
                    taken = wgtReady[col];
                    @(posedge clk);
                    #1;
                end
            end
        end
        wgtValid[col] = 1'b0;
    endtask

    task automatic driveAll();
        fork
            driveAct(0);
            driveAct(1);
            driveWgt(0);
            driveWgt(1);
        join
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (pendingCount() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (pendingCount() != 0) begin
            $display("Test ended with %0d expected sums never received", pendingCount());
            $display("STATUS: FAIL");
            $fatal(1, "Missing results");
        end
        #1;
    endtask

    task automatic runVectors();
        pushExpected();
        driveAll();
        waitDrain();
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic testSingleProduct();
        numVec = 1;
        fillVector(0, 4, KIND_RANDOM);
        runVectors();
    endtask

    task automatic testBackToBack();
        numVec = 3;
        fillVector(0, 4, KIND_RANDOM);
        fillVector(1, 2, KIND_RANDOM);
        fillVector(2, 3, KIND_RANDOM);
        runVectors();
    endtask

    task automatic testSignedExtremes();
        numVec = 4;
        // Single closing pair of -128 times -128
        fillVector(0, 1, KIND_MIN);
        fillVector(1, 4, KIND_MIN);
        fillVector(2, 1, KIND_EXTREME);
        fillVector(3, 3, KIND_EXTREME);
        runVectors();
    endtask

    task automatic testBackPressure();
        numVec = 4;
        for (int v = 0; v < numVec; v++) begin
            fillVector(v, 4, KIND_RANDOM);
        end
        pushExpected();
        readyMode = READY_RANDOM;
        fork
            driveAll();
            begin
                repeat (12) @(posedge clk);
                readyMode = READY_OFF;
                repeat (30) @(posedge clk);
                readyMode = READY_RANDOM;
            end
        join
        waitDrain();
        readyMode = READY_ON;
    endtask

    task automatic testInputGaps();
        numVec = 3;
        gapPct = 40;
        for (int v = 0; v < numVec; v++) begin
            fillVector(v, 4, KIND_RANDOM);
        end
        runVectors();
        gapPct = 0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        actValid = '0;
        wgtValid = '0;
        actIn    = '{default: '0};
        wgtIn    = '{default: '0};
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        testSingleProduct();
        testBackToBack();
        testSignedExtremes();
        testBackPressure();
        testInputGaps();

        // Late duplicates still reach the monitor here
        repeat (5) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== dv/systolicTop_assert.sv ====
// Concurrent assertions on the top-level psum handshake and the state right after reset
`timescale 1ns/1ps

module systolicTop_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             psumValid,
    input systolicPkg::psumBeat_t           psumOut,
    input logic                             psumReady,
    input logic [systolicPkg::NUM_PE-1:0]   peValid
);

    // ==================================================
    // Output handshake
    // ==================================================
    // A waiting beat is never withdrawn
    holdValid: assert property (@(posedge clk) disable iff (!rst_n)
        psumValid && !psumReady |=> psumValid)
        else $error("psumValid dropped before psumReady");

    holdData: assert property (@(posedge clk) disable iff (!rst_n)
        psumValid && !psumReady |=> $stable(psumOut))
        else $error("psumOut changed while waiting for psumReady");

    // ==================================================
    // Reset release
    // ==================================================
    resetIdle: assert property (@(posedge clk)
        $rose(rst_n) |-> !psumValid && (peValid == '0))
        else $error("Valid high in the first cycle after reset release");

endmodule

bind systolicTop systolicTop_assert uAssert (
    .clk       (clk),
    .rst_n     (rst_n),
    .psumValid (psumValid),
    .psumOut   (psumOut),
    .psumReady (psumReady),
    .peValid   (peValid)
);

// ==== files.f ====
logic/systolicPkg.sv
logic/procElem.sv
logic/peArray.sv
logic/psumCollector.sv
logic/systolicTop.sv
dv/systolicTop_assert.sv
dv/systolicTb.sv

// ==== logic/peArray.sv ====
// 2-by-2 grid of processing elements with neighbour wiring, edge sinks and flat psum ports
`timescale 1ns/1ps

module peArray (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic [systolicPkg::NUM_ROWS-1:0]       actValid,
    input  systolicPkg::actBeat_t                  actIn [systolicPkg::NUM_ROWS],
    output logic [systolicPkg::NUM_ROWS-1:0]       actReady,

    input  logic [systolicPkg::NUM_COLS-1:0]       wgtValid,
    input  systolicPkg::wgtBeat_t                  wgtIn [systolicPkg::NUM_COLS],
    output logic [systolicPkg::NUM_COLS-1:0]       wgtReady,

    output logic [systolicPkg::NUM_PE-1:0]         peValid,
    output logic signed [systolicPkg::PSUM_WIDTH-1:0] peSum [systolicPkg::NUM_PE],
    input  logic [systolicPkg::NUM_PE-1:0]         peReady
);
    import systolicPkg::*;

    // ==================================================
    // Grid links
    // ==================================================
    // Horizontal link c feeds element column c, link NUM_COLS is the east edge
    logic     hValid [NUM_ROWS][NUM_COLS+1];
    actBeat_t hAct   [NUM_ROWS][NUM_COLS+1];
    logic     hReady [NUM_ROWS][NUM_COLS+1];

    // Vertical link r feeds element row r, link NUM_ROWS is the south edge
    logic     vValid [NUM_ROWS+1][NUM_COLS];
    wgtBeat_t vWgt   [NUM_ROWS+1][NUM_COLS];
    logic     vReady [NUM_ROWS+1][NUM_COLS];

    // West inputs and east sinks
    for (genvar r = 0; r < NUM_ROWS; r++) begin : gRowEdge
        assign hValid[r][0]        = actValid[r];
        assign hAct[r][0]          = actIn[r];
        assign actReady[r]         = hReady[r][0];
        // Beats leaving the east edge are dropped here
        assign hReady[r][NUM_COLS] = 1'b1;
    end

    // North inputs and south sinks
    for (genvar c = 0; c < NUM_COLS; c++) begin : gColEdge
        assign vValid[0][c]        = wgtValid[c];
        assign vWgt[0][c]          = wgtIn[c];
        assign wgtReady[c]         = vReady[0][c];
        assign vReady[NUM_ROWS][c] = 1'b1;
    end

    // ==================================================
    // Processing elements
    // ==================================================
    for (genvar r = 0; r < NUM_ROWS; r++) begin : gRow
        for (genvar c = 0; c < NUM_COLS; c++) begin : gCol
            localparam int PeIdx = r * NUM_COLS + c;

            procElem uPe (
                .clk        (clk),
                .rst_n      (rst_n),

                .westValid  (hValid[r][c]),
                .westAct    (hAct[r][c]),
                .westReady  (hReady[r][c]),

                .northValid (vValid[r][c]),
                .northWgt   (vWgt[r][c]),
                .northReady (vReady[r][c]),

                .eastValid  (hValid[r][c+1]),
                .eastAct    (hAct[r][c+1]),
                .eastReady  (hReady[r][c+1]),

                .southValid (vValid[r+1][c]),
                .southWgt   (vWgt[r+1][c]),
                .southReady (vReady[r+1][c]),

                .psumValid  (peValid[PeIdx]),
                .psum       (peSum[PeIdx]),
                .psumReady  (peReady[PeIdx])
            );
        end
    end

endmodule

// ==== logic/procElem.sv ====
// Processing element: pair join, signed multiply-accumulate, east/south forwarding stage
`timescale 1ns/1ps

module procElem (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic                                   westValid,
    input  systolicPkg::actBeat_t                  westAct,
    output logic                                   westReady,

    input  logic                                   northValid,
    input  systolicPkg::wgtBeat_t                  northWgt,
    output logic                                   northReady,

    output logic                                   eastValid,
    output systolicPkg::actBeat_t                  eastAct,
    input  logic                                   eastReady,

    output logic                                   southValid,
    output systolicPkg::wgtBeat_t                  southWgt,
    input  logic                                   southReady,

    output logic                                   psumValid,
    output logic signed [systolicPkg::PSUM_WIDTH-1:0] psum,
    input  logic                                   psumReady
);
    import systolicPkg::*;

    logic                         stageValid;
    logic                         stageLast;
    // Per-side flags so a side that already took the held beat is not served twice
    logic                         eastDone;
    logic                         southDone;
    logic                         psumDone;
    logic                         eastTaken;
    logic                         southTaken;
    logic                         psumTaken;
    logic                         advance;
    logic                         accept;
    logic signed [PSUM_WIDTH-1:0] product;
    logic signed [PSUM_WIDTH-1:0] acc;

    // ==================================================
    // Handshake
    // ==================================================
    assign eastTaken  = eastDone | eastReady;
    assign southTaken = southDone | southReady;
    // Psum side only matters when the held pair closed a dot product
    assign psumTaken  = !stageLast | psumDone | psumReady;

    assign advance = !stageValid | (eastTaken & southTaken & psumTaken);
    assign accept  = westValid & northValid & advance;

    assign westReady  = accept;
    assign northReady = accept;

    assign eastValid  = stageValid & !eastDone;
    assign southValid = stageValid & !southDone;
    assign psumValid  = stageValid & stageLast & !psumDone;
    assign psum       = acc;

    // Full-width signed multiply, low bits are the exact product
    assign product = PSUM_WIDTH'(westAct.data) * PSUM_WIDTH'(northWgt.data);

    // ==================================================
    // Stage control and accumulator
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stageValid <= 1'b0;
            stageLast  <= 1'b0;
            eastDone   <= 1'b0;
            southDone  <= 1'b0;
            psumDone   <= 1'b0;
            acc        <= '0;
        end else if (advance) begin
            stageValid <= accept;
            eastDone   <= 1'b0;
            southDone  <= 1'b0;
            psumDone   <= 1'b0;
            if (accept) begin
                stageLast <= westAct.chnLast & northWgt.chnLast;
                // Restart the sum after a closed dot product
                acc       <= stageLast ? product : acc + product;
            end
        end else begin
            eastDone  <= eastDone | eastReady;
            southDone <= southDone | southReady;
            psumDone  <= psumDone | (stageLast & psumReady);
        end
    end

    // Forwarded operands
    always_ff @(posedge clk) begin
        if (accept) begin
            eastAct  <= westAct;
            southWgt <= northWgt;
        end
    end

endmodule

// ==== logic/psumCollector.sv ====
// Round-robin merge of the element psum streams into one row/column tagged stream
`timescale 1ns/1ps

module psumCollector (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic [systolicPkg::NUM_PE-1:0]         peValid,
    input  logic signed [systolicPkg::PSUM_WIDTH-1:0] peSum [systolicPkg::NUM_PE],
    output logic [systolicPkg::NUM_PE-1:0]         peReady,

    output logic                                   outValid,
    output systolicPkg::psumBeat_t                 outBeat,
    input  logic                                   outReady
);
    import systolicPkg::*;

    arbState_t               state;
    // Last granted stream, search starts just after it
    logic [PE_IDX_WIDTH-1:0] rrPtr;
    logic [PE_IDX_WIDTH-1:0] candidate;
    logic [PE_IDX_WIDTH-1:0] grantIdx;
    logic                    grantFound;
    logic                    slotFree;
    logic                    grantValid;

    // ==================================================
    // Grant search
    // ==================================================
    always_comb begin
        grantFound = 1'b0;
        grantIdx   = rrPtr;
        candidate  = rrPtr;
        for (int k = 1; k <= NUM_PE; k++) begin
            candidate = PE_IDX_WIDTH'((int'(rrPtr) + k) % NUM_PE);
            if (!grantFound && peValid[candidate]) begin
                grantFound = 1'b1;
                grantIdx   = candidate;
            end
        end
    end

    // Slot can be refilled in the same cycle it drains
    assign slotFree   = (state == ARB_IDLE) | outReady;
    assign grantValid = slotFree & grantFound;

    always_comb begin
        peReady = '0;
        if (grantValid) begin
            peReady[grantIdx] = 1'b1;
        end
    end

    assign outValid = (state == ARB_HOLD);

    // ==================================================
    // Slot state and pointer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            rrPtr <= PE_IDX_WIDTH'(NUM_PE - 1);
        end else if (grantValid) begin
            state <= ARB_HOLD;
            rrPtr <= grantIdx;
        end else if (outValid && outReady) begin
            state <= ARB_IDLE;
        end
    end

    // Tag comes from the stream index
    always_ff @(posedge clk) begin
        if (grantValid) begin
            outBeat.row   <= 1'(int'(grantIdx) / NUM_COLS);
            outBeat.col   <= 1'(int'(grantIdx) % NUM_COLS);
            outBeat.value <= peSum[grantIdx];
        end
    end

endmodule

// ==== logic/systolicPkg.sv ====
// Array dimensions, data widths, stream beat structs and arbiter state enum
package systolicPkg;

    // ==================================================
    // Widths and dimensions
    // ==================================================
    localparam int ACT_WIDTH  = 8;
    localparam int WGT_WIDTH  = 8;
    // Sums wrap at this width
    localparam int PSUM_WIDTH = 32;

    localparam int NUM_ROWS = 2;
    localparam int NUM_COLS = 2;
    localparam int NUM_PE   = NUM_ROWS * NUM_COLS;

    // Index of one element within the flattened psum streams
    localparam int PE_IDX_WIDTH = $clog2(NUM_PE);

    // ==================================================
    // Stream beats
    // ==================================================
    typedef struct packed {
        logic                        chnLast;
        logic signed [ACT_WIDTH-1:0] data;
    } actBeat_t;

    typedef struct packed {
        logic                        chnLast;
        logic signed [WGT_WIDTH-1:0] data;
    } wgtBeat_t;

    // Finished dot product tagged with its grid position
    typedef struct packed {
        logic                         row;
        logic                         col;
        logic signed [PSUM_WIDTH-1:0] value;
    } psumBeat_t;

    // Collector output slot
    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arbState_t;

endpackage

// ==== logic/systolicTop.sv ====
// Top level joining the processing element array and the psum collector
`timescale 1ns/1ps

module systolicTop (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic [systolicPkg::NUM_ROWS-1:0] actValid,
    input  systolicPkg::actBeat_t            actIn [systolicPkg::NUM_ROWS],
    output logic [systolicPkg::NUM_ROWS-1:0] actReady,

    input  logic [systolicPkg::NUM_COLS-1:0] wgtValid,
    input  systolicPkg::wgtBeat_t            wgtIn [systolicPkg::NUM_COLS],
    output logic [systolicPkg::NUM_COLS-1:0] wgtReady,

    output logic                             psumValid,
    output systolicPkg::psumBeat_t           psumOut,
    input  logic                             psumReady
);
    import systolicPkg::*;

    // Untagged sums between array and collector
    logic [NUM_PE-1:0]            peValid;
    logic signed [PSUM_WIDTH-1:0] peSum [NUM_PE];
    logic [NUM_PE-1:0]            peReady;

    peArray uArray (
        .clk      (clk),
        .rst_n    (rst_n),
        .actValid (actValid),
        .actIn    (actIn),
        .actReady (actReady),
        .wgtValid (wgtValid),
        .wgtIn    (wgtIn),
        .wgtReady (wgtReady),
        .peValid  (peValid),
        .peSum    (peSum),
        .peReady  (peReady)
    );

    psumCollector uCollector (
        .clk      (clk),
        .rst_n    (rst_n),
        .peValid  (peValid),
        .peSum    (peSum),
        .peReady  (peReady),
        .outValid (psumValid),
        .outBeat  (psumOut),
        .outReady (psumReady)
    );

endmodule
